//--- digit_run_matcher.sv
`default_nettype none

`include "scan_cfg.svh"

module digit_run_matcher
   import scan_stream_pkg::*, scan_match_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         rst_n,
   input  wire byte_t        char_in,
   input  wire logic         char_in_vld,
   input  wire digit_state_t state_in,
   input  wire logic         state_in_vld,
   output digit_state_t      state_out,
   output logic              accept_out
);

   localparam digit_state_t RUN_MAX = digit_state_t'(`SCAN_DIGIT_RUN);

   // ASCII 0 to 9
   logic is_digit;

   assign is_digit = (char_in >= 8'h30) && (char_in <= 8'h39);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         if (state_in_vld)
            state_out <= state_in;
         else if (char_in_vld)
         begin
            if (!is_digit)
               state_out <= '0;
            // Saturated run stays put, so a longer run counts once
            else if (state_out != RUN_MAX)
            begin
               state_out  <= state_out + 1'b1;
               accept_out <= (state_out == RUN_MAX - 1'b1);
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- literal_matcher.sv
`default_nettype none

`include "scan_cfg.svh"

module literal_matcher
   import scan_stream_pkg::*, scan_match_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire byte_t      char_in,
   input  wire logic       char_in_vld,
   input  wire lit_state_t state_in,
   input  wire logic       state_in_vld,
   output lit_state_t      state_out,
   output logic            accept_out
);

   // Byte expected at the current prefix length
   byte_t      exp_char;
   lit_state_t next_state;
   logic       hit;

   always_comb
   begin
      case (state_out)
         3'd0:    exp_char = `SCAN_LIT_B0;
         3'd1:    exp_char = `SCAN_LIT_B1;
         3'd2:    exp_char = `SCAN_LIT_B2;
         default: exp_char = `SCAN_LIT_B3;
      endcase
      hit = 1'b0;
      if (char_in == exp_char)
      begin
         next_state = state_out + 3'd1;
         // Full word seen, start over from empty prefix
         if (next_state == lit_state_t'(`SCAN_LIT_LEN))
         begin
            hit        = 1'b1;
            next_state = '0;
         end
      end
      // NN then N still ends in NN
      else if ((state_out == 3'd2) && (char_in == `SCAN_LIT_B1))
         next_state = 3'd2;
      // Any other N restarts with a one-byte prefix
      else if (char_in == `SCAN_LIT_B0)
         next_state = 3'd1;
      else
         next_state = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         // Restore from context wins, never overlaps a byte anyway
         if (state_in_vld)
            state_out <= state_in;
         else if (char_in_vld)
         begin
            state_out  <= next_state;
            accept_out <= hit;
         end
      end
   end

endmodule

`default_nettype wire

//--- payload_scanner.f
+incdir+.
scan_stream_pkg.sv
scan_match_pkg.sv
literal_matcher.sv
digit_run_matcher.sv
stream_context.sv
payload_scanner.sv
payload_scanner_asserts.sv
payload_scanner_tb.sv

//--- payload_scanner.sv
`default_nettype none

module payload_scanner
   import scan_stream_pkg::*, scan_match_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       load_state,
   input  wire stream_id_t stream_id,
   input  wire logic       new_stream_id,
   input  wire byte_t      char_in,
   input  wire logic       char_in_vld,
   input  wire logic       eop,
   input  wire logic [1:0] enable,
   output match_count_t    lit_count,
   output match_count_t    digit_count,
   output logic            lit_fired,
   output logic            digit_fired
);

   // Literal path between context and matcher
   lit_state_t lit_state_in;
   lit_state_t lit_state_out;
   logic       lit_state_in_vld;
   logic       lit_accept;

   // Digit-run path between context and matcher
   digit_state_t dig_state_in;
   digit_state_t dig_state_out;
   logic         dig_state_in_vld;
   logic         dig_accept;

   stream_context #(.state_t(lit_state_t)) u_lit_ctx
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .enable        (enable[MATCH_LIT]),
      .state_out     (lit_state_out),
      .accept_out    (lit_accept),
      .state_in      (lit_state_in),
      .state_in_vld  (lit_state_in_vld),
      .count         (lit_count),
      .fired         (lit_fired)
   );

   literal_matcher u_lit
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (lit_state_in),
      .state_in_vld (lit_state_in_vld),
      .state_out    (lit_state_out),
      .accept_out   (lit_accept)
   );

   stream_context #(.state_t(digit_state_t)) u_dig_ctx
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .enable        (enable[MATCH_DIGIT]),
      .state_out     (dig_state_out),
      .accept_out    (dig_accept),
      .state_in      (dig_state_in),
      .state_in_vld  (dig_state_in_vld),
      .count         (digit_count),
      .fired         (digit_fired)
   );

   digit_run_matcher u_dig
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (dig_state_in),
      .state_in_vld (dig_state_in_vld),
      .state_out    (dig_state_out),
      .accept_out   (dig_accept)
   );

endmodule

`default_nettype wire

//--- payload_scanner_asserts.sv
`default_nettype none

module payload_scanner_asserts
   import scan_stream_pkg::*;
(
   input wire logic         clk,
   input wire logic         rst_n,
   input wire logic         load_state,
   input wire logic         eop,
   input wire logic         state_in_vld,
   input wire logic         fired,
   input wire match_count_t count
);

   // Restore strobe comes exactly one cycle after load_state
   a_strobe_after_load: assert property (@(posedge clk) disable iff (!rst_n)
      load_state |=> state_in_vld)
      else $error("state_in_vld missing one cycle after load_state");

   a_strobe_only_after_load: assert property (@(posedge clk) disable iff (!rst_n)
      state_in_vld |-> $past(load_state))
      else $error("state_in_vld without load_state in the cycle before");

   // Speculative flag starts each packet cleared
   a_fired_cleared: assert property (@(posedge clk) disable iff (!rst_n)
      load_state |=> !fired)
      else $error("fired still high one cycle after load_state");

   // Counter only moves on the commit cycle
   a_count_on_eop: assert property (@(posedge clk) disable iff (!rst_n)
      (count != $past(count)) |-> $past(eop))
      else $error("count changed outside the cycle after eop");

endmodule

bind stream_context payload_scanner_asserts u_ctx_asserts
(
   .clk          (clk),
   .rst_n        (rst_n),
   .load_state   (load_state),
   .eop          (eop),
   .state_in_vld (state_in_vld),
   .fired        (fired),
   .count        (count)
);

`default_nettype wire

//--- payload_scanner_tb.sv
`default_nettype none

`include "scan_cfg.svh"

module payload_scanner_tb
   import scan_stream_pkg::*, scan_match_pkg::*;
();

   localparam int          CLK_PERIOD  = 100;
   localparam int          N_RANDOM    = 40;
   localparam int          MAX_LEN     = 16;
   localparam int          MAX_RECORDS = 64;
   // Load, gap, bytes, gap, eop and check per packet, plus reset and slack
   localparam int          WD_CYCLES   = MAX_RECORDS * (MAX_LEN + 6) + 100;
   localparam logic [31:0] SEED        = 32'ha188_859b;
   localparam logic [31:0] LIT_WORD    =
      {`SCAN_LIT_B0, `SCAN_LIT_B1, `SCAN_LIT_B2, `SCAN_LIT_B3};
   // Random bytes lean toward pattern letters and digits
   localparam string       ALPHABET    = "NNTP012345";

   logic         clk;
   logic         rst_n;
   logic         load_state;
   stream_id_t   stream_id;
   logic         new_stream_id;
   byte_t        char_in;
   logic         char_in_vld;
   logic         eop;
   logic [1:0]   enable;
   match_count_t lit_count;
   match_count_t digit_count;
   logic         lit_fired;
   logic         digit_fired;

   logic [15:0]  td [512];
   // Reference copy of the per-stream saved states
   lit_state_t   lit_mem [`SCAN_STREAMS];
   digit_state_t dig_mem [`SCAN_STREAMS];
   bit           lit_saved [`SCAN_STREAMS];
   bit           dig_saved [`SCAN_STREAMS];
   match_count_t model_lit;
   match_count_t model_dig;
   byte_t        pkt [MAX_LEN];
   int           errors;
   int           tests;

   payload_scanner DUT
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .enable        (enable),
      .lit_count     (lit_count),
      .digit_count   (digit_count),
      .lit_fired     (lit_fired),
      .digit_fired   (digit_fired)
   );

   initial
      clk = 1'b0;
   always
      #(CLK_PERIOD / 2) clk = ~clk;

   // Longest suffix that is a prefix of NNTP, hit on the full word
   function automatic lit_state_t lit_next(input lit_state_t s, input byte_t c,
                                           output logic hit);
      byte_t want;
      want = LIT_WORD[31 - 8 * s -: 8];
      hit  = 1'b0;
      if (c == want)
      begin
         if (s == lit_state_t'(`SCAN_LIT_LEN - 1))
         begin
            hit = 1'b1;
            return '0;
         end
         return s + 3'd1;
      end
      // NN then N still leaves NN
      if ((s == 3'd2) && (c == `SCAN_LIT_B0))
         return s;
      return (c == `SCAN_LIT_B0) ? 3'd1 : 3'd0;
   endfunction

   // Run of digits, hit only when the run first reaches the threshold
   function automatic digit_state_t dig_next(input digit_state_t s, input byte_t c,
                                             output logic hit);
      hit = 1'b0;
      if ((c < "0") || (c > "9"))
         return '0;
      if (s == digit_state_t'(`SCAN_DIGIT_RUN))
         return s;
      hit = (s == digit_state_t'(`SCAN_DIGIT_RUN - 1));
      return s + 3'd1;
   endfunction

   task automatic check_count(input string name, input match_count_t got,
                              input match_count_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   // Runs the packet through the reference and commits like the context block
   task automatic model_packet(input stream_id_t sid, input logic is_new,
                               input logic [1:0] en, input int len,
                               output match_count_t e_lit, output match_count_t e_dig,
                               output logic e_lf, output logic e_df);
      lit_state_t   ls;
      digit_state_t ds;
      logic         h;
      ls   = is_new ? '0 : lit_mem[sid];
      ds   = is_new ? '0 : dig_mem[sid];
      e_lf = 1'b0;
      e_df = 1'b0;
      for (int i = 0; i < len; i++)
      begin
         ls   = lit_next(ls, pkt[i], h);
         e_lf = e_lf | h;
         ds   = dig_next(ds, pkt[i], h);
         e_df = e_df | h;
      end
      // Disabled matcher drops its flag and keeps the older save
      if (en[MATCH_LIT])
      begin
         lit_mem[sid]   = ls;
         lit_saved[sid] = 1'b1;
         model_lit      = model_lit + match_count_t'(e_lf);
      end
      else
         e_lf = 1'b0;
      if (en[MATCH_DIGIT])
      begin
         dig_mem[sid]   = ds;
         dig_saved[sid] = 1'b1;
         model_dig      = model_dig + match_count_t'(e_df);
      end
      else
         e_df = 1'b0;
      e_lit = model_lit;
      e_dig = model_dig;
   endtask

   // Drives one packet on falling edges and checks after the commit
   task automatic run_packet(input stream_id_t sid, input logic is_new,
                             input logic [1:0] en, input int len,
                             input match_count_t e_lit, input match_count_t e_dig,
                             input logic e_lf, input logic e_df);
      int err_before;
      err_before = errors;
      @(negedge clk);
      load_state    = 1'b1;
      stream_id     = sid;
      new_stream_id = is_new;
      @(negedge clk);
      load_state = 1'b0;
      // First byte lands two cycles after load_state
      for (int i = 0; i < len; i++)
      begin
         @(negedge clk);
         char_in     = pkt[i];
         char_in_vld = 1'b1;
      end
      @(negedge clk);
      char_in_vld = 1'b0;
      @(negedge clk);
      eop    = 1'b1;
      enable = en;
      @(negedge clk);
      eop = 1'b0;
      // Count and fired settled on the edge after eop
      check_count("lit_count", lit_count, e_lit);
      check_count("digit_count", digit_count, e_dig);
      check_flag("lit_fired", lit_fired, e_lf);
      check_flag("digit_fired", digit_fired, e_df);
      tests++;
      $display("packet %0d stream %0d len %0d enable %b: %s", tests, sid, len, en,
               (errors == err_before) ? "ok" : "failed");
   endtask

   // Hang guard sized from the record count and longest packet
   initial
   begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, a packet never completed", WD_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      int           idx;
      int           len;
      stream_id_t   sid;
      logic         nw;
      logic [1:0]   en;
      match_count_t e_lit;
      match_count_t e_dig;
      logic         e_lf;
      logic         e_df;
      void'($urandom(SEED));
      rst_n         = 1'b0;
      load_state    = 1'b0;
      stream_id     = '0;
      new_stream_id = 1'b0;
      char_in       = '0;
      char_in_vld   = 1'b0;
      eop           = 1'b0;
      enable        = '0;
      errors        = 0;
      tests         = 0;
      model_lit     = '0;
      model_dig     = '0;
      for (int s = 0; s < `SCAN_STREAMS; s++)
      begin
         lit_saved[s] = 1'b0;
         dig_saved[s] = 1'b0;
      end
      $readmemh("payload_scanner_testdata.txt", td);
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      // Fixed records, expectations come from the file
      idx = 0;
      while ((idx < 480) && (td[idx] != 16'hFFFF))
      begin
         sid = stream_id_t'(td[idx]);
         nw  = td[idx + 1][0];
         en  = td[idx + 2][1:0];
         len = int'(td[idx + 3]);
         idx = idx + 4;
         for (int i = 0; i < len; i++)
            pkt[i] = byte_t'(td[idx + i]);
         idx = idx + len;
         // Keeps the reference in step for the random section
         model_packet(sid, nw, en, len, e_lit, e_dig, e_lf, e_df);
         run_packet(sid, nw, en, len, td[idx], td[idx + 1], td[idx + 2][0],
                    td[idx + 3][0]);
         idx = idx + 4;
      end

      // Random streams and payloads checked against the reference
      for (int n = 0; n < N_RANDOM; n++)
      begin
         sid = stream_id_t'($urandom_range(15, 0));
         // Reuse only a stream that both matchers have saved
         nw  = !(lit_saved[sid] && dig_saved[sid]) || ($urandom_range(5, 0) == 0);
         en  = 2'($urandom_range(3, 0));
         len = int'($urandom_range(MAX_LEN, 1));
         for (int i = 0; i < len; i++)
            pkt[i] = ALPHABET[$urandom_range(ALPHABET.len() - 1, 0)];
         model_packet(sid, nw, en, len, e_lit, e_dig, e_lf, e_df);
         run_packet(sid, nw, en, len, e_lit, e_dig, e_lf, e_df);
      end

      $display("Totals: %0d packets, %0d errors", tests, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

//--- payload_scanner_testdata.txt
// Columns (hex): stream, new, enable, length, payload bytes, then the expected
// lit_count, digit_count, lit_fired, digit_fired after eop
// NNTP twice in one packet adds one
01 1 3 9 4E 4E 54 50 78 4E 4E 54 50 1 0 1 0
// NNN then TP on the same stream
02 1 3 5 61 62 4E 4E 4E 1 0 0 0
02 0 3 3 54 50 7A 2 0 1 0
// Same split, second packet flagged as a new stream
04 1 3 3 4E 4E 4E 2 0 0 0
04 1 3 3 54 50 7A 2 0 0 0
// Five digits across a packet boundary
05 1 3 5 61 62 31 32 33 2 0 0 0
05 0 3 3 34 35 78 2 1 0 1
// Six digits count once, a letter restarts the run
06 1 3 6 31 32 33 34 35 36 2 2 0 1
06 0 3 6 31 32 61 33 34 35 2 2 0 0
06 0 3 2 36 37 2 3 0 1
// Literal disabled at eop, next packet resumes from the older save
07 1 3 2 4E 4E 2 3 0 0
07 0 2 4 54 50 4E 4E 2 3 0 0
07 0 3 2 54 50 3 3 1 0
// Digit matcher disabled at eop
08 1 3 2 31 32 3 3 0 0
08 0 1 3 33 34 35 3 3 0 0
08 0 3 3 33 34 35 3 4 0 1
// Streams 3 and 40 interleaved
03 1 3 2 4E 4E 3 4 0 0
28 1 3 3 4E 4E 54 3 4 0 0
03 0 3 1 50 3 4 0 0
28 0 3 1 50 4 4 1 0
03 0 3 4 4E 4E 54 50 5 4 1 0
// End marker
FFFF

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the payload scanner testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module payload_scanner_tb -f payload_scanner.f \
   --Mdir "$OBJ" -o sim_payload_scanner
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/sim_payload_scanner" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The testbench prints the fail line on any failed check or timeout
if grep -q '\*\* FAIL \*\*' "$LOG"; then
   echo "Testbench reported failure, see $LOG"
   exit 1
fi
exit 0

//--- scan_cfg.svh
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// Number of interleaved stream slots held by each context block
`define SCAN_STREAMS 64

// Stream id width, enough to index every slot
`define SCAN_SID_W 6

// Per-matcher match counter width
`define SCAN_CNT_W 16

// Literal command word, one byte per position
`define SCAN_LIT_LEN 4
`define SCAN_LIT_B0 8'h4E
`define SCAN_LIT_B1 8'h4E
`define SCAN_LIT_B2 8'h54
`define SCAN_LIT_B3 8'h50

// Consecutive ASCII digits needed for a digit-run hit
`define SCAN_DIGIT_RUN 5

`endif

//--- scan_match_pkg.sv
`default_nettype none

`include "scan_cfg.svh"

package scan_match_pkg;

   // Literal matcher state
   // Length of the longest stream suffix that is also a pattern prefix
   // Never holds the full length, the automaton wraps to 0 on a hit
   typedef logic [2:0] lit_state_t;

   // Digit matcher state
   // Current run of digits, saturates at the threshold
   typedef logic [$clog2(`SCAN_DIGIT_RUN + 1)-1:0] digit_state_t;

   // Bit positions in the enable mask, one per matcher
   typedef enum int unsigned
   {
      MATCH_LIT   = 0,
      MATCH_DIGIT = 1
   } matcher_idx_e;

endpackage

`default_nettype wire

//--- scan_stream_pkg.sv
`default_nettype none

`include "scan_cfg.svh"

package scan_stream_pkg;

   // Stream slot identifier, comes from the external classifier
   typedef logic [`SCAN_SID_W-1:0] stream_id_t;

   // One payload character
   typedef logic [7:0] byte_t;

   // Match counter per matcher
   // Plain unsigned add, so it wraps at its top value
   typedef logic [`SCAN_CNT_W-1:0] match_count_t;

endpackage

`default_nettype wire

//--- stream_context.sv
`default_nettype none

`include "scan_cfg.svh"

module stream_context
   import scan_stream_pkg::*;
#(
   parameter type state_t = logic
)
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       load_state,
   input  wire logic       new_stream_id,
   input  wire stream_id_t stream_id,
   input  wire logic       eop,
   input  wire logic       enable,
   input  wire state_t     state_out,
   input  wire logic       accept_out,
   output state_t          state_in,
   output logic            state_in_vld,
   output match_count_t    count,
   output logic            fired
);

   // Saved matcher state, one entry per stream slot
   state_t state_mem [`SCAN_STREAMS];

   // Restore path
   // New stream gets an empty state, known stream gets its saved one
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream_id)
            state_in <= '0;
         else
            state_in <= state_mem[stream_id];
      end
   end

   // One-cycle strobe into the matcher, the cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // Save path
   // Only an enabled eop commits, a disabled one leaves the old entry
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   // Speculative flag and committed count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         fired <= 1'b0;
      end
      else
      begin
         // Cleared at every packet start
         if (load_state)
            fired <= 1'b0;
         // Any hit in the packet sets it, several hits still give one
         if (accept_out)
            fired <= 1'b1;
         if (eop)
         begin
            if (enable)
               count <= count + match_count_t'(fired);
            else
               fired <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire
